// ==== logic/mem_sys_pkg.sv ====
// Package with the data width, byte count, word and address types, and AXI-Lite codes.
`default_nettype none

package mem_sys_pkg;

	// Data and address width.
	localparam int XLEN = 32;

	// Bytes per word.
	localparam int BYTES = XLEN / 8;

	// One data word.
	typedef logic [XLEN-1:0] data_t;

	// Byte address, the low two bits select a byte lane.
	typedef logic [XLEN-1:0] addr_t;

	// Byte enables, one per lane, bit 0 for data bits 7:0.
	typedef logic [BYTES-1:0] be_t;

	// AXI response code for a normal access.
	localparam logic [1:0] AXI_OKAY = 2'b00;

	// Unprivileged, secure, data access.
	localparam logic [2:0] AXI_PROT_NONE = 3'b000;

endpackage : mem_sys_pkg

`default_nettype wire

// ==== logic/axil_if.sv ====
// AXI-Lite interface with its five channels and master, slave and monitor modports.
`timescale 1ns/1ps
`default_nettype none

interface axil_if (
	input logic clk,
	input logic rst_n
);
	import mem_sys_pkg::*;

	// Write address channel.
	addr_t awaddr;
	logic [2:0] awprot;
	logic awvalid;
	logic awready;

	// Write data channel.
	data_t wdata;
	be_t wstrb;
	logic wvalid;
	logic wready;

	// Write response channel.
	logic [1:0] bresp;
	logic bvalid;
	logic bready;

	// Read address channel.
	addr_t araddr;
	logic [2:0] arprot;
	logic arvalid;
	logic arready;

	// Read data channel.
	data_t rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;

	modport master (
		input clk, rst_n,
		output awaddr, awprot, awvalid, wdata, wstrb, wvalid, bready,
		output araddr, arprot, arvalid, rready,
		input awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
	);

	modport slave (
		input clk, rst_n,
		input awaddr, awprot, awvalid, wdata, wstrb, wvalid, bready,
		input araddr, arprot, arvalid, rready,
		output awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
	);

	modport mon (
		input clk, rst_n,
		input awaddr, awprot, awvalid, awready, wdata, wstrb, wvalid, wready,
		input bresp, bvalid, bready, araddr, arprot, arvalid, arready,
		input rdata, rresp, rvalid, rready
	);

endinterface : axil_if

`default_nettype wire

// ==== logic/mem_sys_axil.sv ====
// Bridge FSM from the core request port to an AXI-Lite master.
`timescale 1ns/1ps
`default_nettype none

module mem_sys_axil (
	input logic clk,
	input logic rst_n,

	input mem_sys_pkg::addr_t addr,
	input mem_sys_pkg::data_t data_in,
	input logic wr,
	input logic rd,
	input logic valid,
	input mem_sys_pkg::be_t be,

	output mem_sys_pkg::data_t data_out,
	output logic done,

	axil_if.master axil
);
	import mem_sys_pkg::*;

	typedef enum logic [1:0] {
		IDLE,
		READ,
		WRITE
	} state_t;

	state_t state;

	// Request captured on acceptance.
	addr_t req_addr;
	data_t req_data;
	be_t req_be;

	// Per-channel completion flags.
	logic aw_done;
	logic w_done;
	logic ar_done;

	logic accept;
	logic aw_hs;
	logic w_hs;
	logic b_hs;
	logic ar_hs;
	logic r_hs;

	// Requests are only taken while idle.
	assign accept = (state == IDLE) && valid && (wr || rd);

	assign aw_hs = axil.awvalid && axil.awready;
	assign w_hs = axil.wvalid && axil.wready;
	assign b_hs = axil.bvalid && axil.bready;
	assign ar_hs = axil.arvalid && axil.arready;
	assign r_hs = axil.rvalid && axil.rready;

	always_ff @(posedge clk) begin
		if (accept) begin
			req_addr <= addr;
			req_data <= data_in;
			req_be <= be;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
			aw_done <= 1'b0;
			w_done <= 1'b0;
			ar_done <= 1'b0;
			done <= 1'b0;
			data_out <= '0;
		end else begin
			done <= 1'b0;
			case (state)
				IDLE: begin
					// Write wins when both are set.
					if (accept) begin
						state <= wr ? WRITE : READ;
					end
				end
				WRITE: begin
					if (aw_hs) begin
						aw_done <= 1'b1;
					end
					if (w_hs) begin
						w_done <= 1'b1;
					end
					if (b_hs) begin
						aw_done <= 1'b0;
						w_done <= 1'b0;
						done <= 1'b1;
						state <= IDLE;
					end
				end
				READ: begin
					if (ar_hs) begin
						ar_done <= 1'b1;
					end
					if (r_hs) begin
						ar_done <= 1'b0;
						data_out <= axil.rdata;
						done <= 1'b1;
						state <= IDLE;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// AW and W run independently, B opens once both are through.
	assign axil.awaddr = req_addr;
	assign axil.awprot = AXI_PROT_NONE;
	assign axil.awvalid = (state == WRITE) && !aw_done;
	assign axil.wdata = req_data;
	assign axil.wstrb = req_be;
	assign axil.wvalid = (state == WRITE) && !w_done;
	assign axil.bready = (state == WRITE) && aw_done && w_done;

	assign axil.araddr = req_addr;
	assign axil.arprot = AXI_PROT_NONE;
	assign axil.arvalid = (state == READ) && !ar_done;
	assign axil.rready = (state == READ) && ar_done;

	// Request valids hold until the target takes them.
	a_aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(axil.awvalid && !axil.awready) |=> axil.awvalid);
	a_w_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(axil.wvalid && !axil.wready) |=> axil.wvalid);
	a_ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(axil.arvalid && !axil.arready) |=> axil.arvalid);

	// Done only in the first idle cycle after an operation.
	a_done_return: assert property (@(posedge clk) disable iff (!rst_n)
		done |-> (state == IDLE) && ($past(state) != IDLE));

	// Responses are dropped here, so the target must only answer OKAY.
	a_resp_okay: assert property (@(posedge clk) disable iff (!rst_n)
		(b_hs || r_hs) |-> ((b_hs ? axil.bresp : axil.rresp) == AXI_OKAY));

endmodule : mem_sys_axil

`default_nettype wire

// ==== logic/axil_sram.sv ====
// AXI-Lite slave word memory with byte strobes and a delayed ready on each request channel.
`timescale 1ns/1ps
`default_nettype none

module axil_sram #(
	parameter int MEM_AWORDS = 6,
	parameter int READY_DELAY = 2
) (
	axil_if.slave axil
);
	import mem_sys_pkg::*;

	localparam int DEPTH = 1 << MEM_AWORDS;
	localparam int CW = (READY_DELAY > 0) ? $clog2(READY_DELAY + 1) : 1;
	localparam logic [CW-1:0] DELAY = CW'(READY_DELAY);

	// Channel slots in the ready logic.
	localparam int CH_AW = 0;
	localparam int CH_W = 1;
	localparam int CH_AR = 2;

	data_t mem [DEPTH];

	logic [2:0] chan_valid;
	logic [2:0] chan_open;
	logic [2:0] chan_ready;
	logic [CW-1:0] wait_cnt [3];

	logic aw_got;
	logic w_got;
	logic bvalid_q;
	logic rvalid_q;
	data_t rdata_q;

	// Held halves of a write whose partner is still missing.
	logic [MEM_AWORDS-1:0] aw_idx_q;
	data_t w_data_q;
	be_t w_strb_q;

	logic aw_take;
	logic w_take;
	logic ar_take;
	logic wr_fire;
	logic [MEM_AWORDS-1:0] wr_idx;
	data_t wr_data;
	be_t wr_strb;

	assign chan_valid = {axil.arvalid, axil.wvalid, axil.awvalid};

	// No new request while its response is still pending.
	assign chan_open = {!rvalid_q, !w_got && !bvalid_q, !aw_got && !bvalid_q};

	always_comb begin
		for (int i = 0; i < 3; i++) begin
			chan_ready[i] = chan_valid[i] && chan_open[i] && (wait_cnt[i] == DELAY);
		end
	end

	always_ff @(posedge axil.clk or negedge axil.rst_n) begin
		if (!axil.rst_n) begin
			for (int i = 0; i < 3; i++) begin
				wait_cnt[i] <= '0;
			end
		end else begin
			for (int i = 0; i < 3; i++) begin
				if (!(chan_valid[i] && chan_open[i]) || chan_ready[i]) begin
					wait_cnt[i] <= '0;
				end else begin
					wait_cnt[i] <= wait_cnt[i] + 1'b1;
				end
			end
		end
	end

	assign axil.awready = chan_ready[CH_AW];
	assign axil.wready = chan_ready[CH_W];
	assign axil.arready = chan_ready[CH_AR];

	assign aw_take = chan_ready[CH_AW];
	assign w_take = chan_ready[CH_W];
	assign ar_take = chan_ready[CH_AR];

	// Write goes in on the edge the second half arrives.
	assign wr_fire = (aw_got || aw_take) && (w_got || w_take);
	assign wr_idx = aw_take ? axil.awaddr[MEM_AWORDS+1:2] : aw_idx_q;
	assign wr_data = w_take ? axil.wdata : w_data_q;
	assign wr_strb = w_take ? axil.wstrb : w_strb_q;

	always_ff @(posedge axil.clk) begin
		if (aw_take) begin
			aw_idx_q <= axil.awaddr[MEM_AWORDS+1:2];
		end
		if (w_take) begin
			w_data_q <= axil.wdata;
			w_strb_q <= axil.wstrb;
		end
		if (ar_take) begin
			rdata_q <= mem[axil.araddr[MEM_AWORDS+1:2]];
		end
	end

	always_ff @(posedge axil.clk or negedge axil.rst_n) begin
		if (!axil.rst_n) begin
			for (int i = 0; i < DEPTH; i++) begin
				mem[i] <= '0;
			end
		end else if (wr_fire) begin
			for (int b = 0; b < BYTES; b++) begin
				if (wr_strb[b]) begin
					mem[wr_idx][8*b +: 8] <= wr_data[8*b +: 8];
				end
			end
		end
	end

	always_ff @(posedge axil.clk or negedge axil.rst_n) begin
		if (!axil.rst_n) begin
			aw_got <= 1'b0;
			w_got <= 1'b0;
			bvalid_q <= 1'b0;
			rvalid_q <= 1'b0;
		end else begin
			if (wr_fire) begin
				aw_got <= 1'b0;
				w_got <= 1'b0;
				bvalid_q <= 1'b1;
			end else begin
				if (aw_take) begin
					aw_got <= 1'b1;
				end
				if (w_take) begin
					w_got <= 1'b1;
				end
				if (bvalid_q && axil.bready) begin
					bvalid_q <= 1'b0;
				end
			end
			if (ar_take) begin
				rvalid_q <= 1'b1;
			end else if (rvalid_q && axil.rready) begin
				rvalid_q <= 1'b0;
			end
		end
	end

	assign axil.bvalid = bvalid_q;
	assign axil.bresp = AXI_OKAY;
	assign axil.rvalid = rvalid_q;
	assign axil.rdata = rdata_q;
	assign axil.rresp = AXI_OKAY;

	// Responses wait for the master, read data with them.
	a_b_hold: assert property (@(posedge axil.clk) disable iff (!axil.rst_n)
		(bvalid_q && !axil.bready) |=> bvalid_q);
	a_r_hold: assert property (@(posedge axil.clk) disable iff (!axil.rst_n)
		(rvalid_q && !axil.rready) |=> rvalid_q && $stable(rdata_q));

endmodule : axil_sram

`default_nettype wire

// ==== logic/mem_sys_top.sv ====
// Top level joining the request bridge and the AXI-Lite word memory.
`timescale 1ns/1ps
`default_nettype none

module mem_sys_top #(
	parameter int MEM_AWORDS = 6,
	parameter int READY_DELAY = 2
) (
	input logic clk,
	input logic rst_n,

	input mem_sys_pkg::addr_t addr,
	input mem_sys_pkg::data_t data_in,
	input logic wr,
	input logic rd,
	input logic valid,
	input mem_sys_pkg::be_t be,

	output mem_sys_pkg::data_t data_out,
	output logic done
);

	// Bus between bridge and memory.
	axil_if axil_bus (
		.clk(clk),
		.rst_n(rst_n)
	);

	mem_sys_axil bridge_inst (
		.clk(clk),
		.rst_n(rst_n),
		.addr(addr),
		.data_in(data_in),
		.wr(wr),
		.rd(rd),
		.valid(valid),
		.be(be),
		.data_out(data_out),
		.done(done),
		.axil(axil_bus.master)
	);

	axil_sram #(
		.MEM_AWORDS(MEM_AWORDS),
		.READY_DELAY(READY_DELAY)
	) sram_inst (
		.axil(axil_bus.slave)
	);

endmodule : mem_sys_top

`default_nettype wire

// ==== bench/mem_sys_tb.sv ====
// Testbench for the memory subsystem, driven from a pattern file with a byte-enable reference.
`timescale 1ns/1ps
`default_nettype none

module mem_sys_tb;
	import mem_sys_pkg::*;

	localparam string PATTERN_FILE = "bench/mem_sys_patterns.txt";
	localparam int RESET_CYCLES = 10;
	localparam int CYCLES_PER_LINE = 64;
	// Word-address bits of the DUT default.
	localparam int WORD_BITS = 6;

	logic clk;
	logic rst_n;
	addr_t addr;
	data_t data_in;
	logic wr;
	logic rd;
	logic valid;
	be_t be;
	data_t data_out;
	logic done;

	// One entry per pattern line.
	byte op_q[$];
	addr_t addr_q[$];
	data_t data_q[$];
	be_t be_q[$];
	data_t exp_q[$];

	data_t ref_mem [1 << WORD_BITS];
	integer seed = 32'h1690;
	int errors = 0;
	int checks = 0;
	int cycles = 0;
	int cycle_limit = 0;
	logic pending = 1'b0;
	data_t last_read = '0;

	mem_sys_top mem_sys_top_inst (
		.clk(clk),
		.rst_n(rst_n),
		.addr(addr),
		.data_in(data_in),
		.wr(wr),
		.rd(rd),
		.valid(valid),
		.be(be),
		.data_out(data_out),
		.done(done)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic load_patterns;
		int fd;
		int n;
		int line_no;
		string line;
		byte op;
		addr_t a;
		data_t d;
		be_t b;
		data_t x;
		fd = $fopen(PATTERN_FILE, "r");
		if (fd == 0) begin
			$display("Cannot open the pattern file %s", PATTERN_FILE);
			errors++;
			return;
		end
		line_no = 0;
		while ($fgets(line, fd) > 0) begin
			line_no++;
			if (line.len() < 2 || line[0] == "#")
				continue;
			n = $sscanf(line, "%c %h %h %h %h", op, a, d, b, x);
			if (n != 5 || (op != "W" && op != "R")) begin
				$display("Bad pattern line %0d, fields could not be read", line_no);
				errors++;
			end else begin
				op_q.push_back(op);
				addr_q.push_back(a);
				data_q.push_back(d);
				be_q.push_back(b);
				exp_q.push_back(x);
			end
		end
		$fclose(fd);
	endtask

	// Advance one cycle and match done to the pending operation.
	task automatic tick;
		@(negedge clk);
		if (done) begin
			if (pending) begin
				pending = 1'b0;
			end else begin
				$display("Fail time=%0t done got=1 exp=0", $time);
				errors++;
			end
		end
	endtask

	task automatic check_word(input string name, input data_t got, input data_t exp);
		checks++;
		if (got !== exp) begin
			$display("Fail time=%0t %s got=%h exp=%h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic run_op(input int k);
		int idx;
		addr_t a;
		data_t d;
		be_t b;
		data_t model;
		a = addr_q[k];
		d = data_q[k];
		b = be_q[k];
		idx = int'(a[WORD_BITS+1:2]);
		model = ref_mem[idx];
		if (op_q[k] == "W") begin
			for (int i = 0; i < BYTES; i++) begin
				if (b[i])
					model[8*i +: 8] = d[8*i +: 8];
			end
			ref_mem[idx] = model;
		end
		if (model !== exp_q[k]) begin
			$display("Bad pattern line for operation %0d, file says %h, byte rule gives %h",
				k, exp_q[k], model);
			errors++;
		end
		tick();
		addr = a;
		data_in = d;
		be = b;
		wr = (op_q[k] == "W");
		rd = (op_q[k] == "R");
		valid = 1'b1;
		pending = 1'b1;
		tick();
		// Busy now, so this request must be dropped.
		addr = $random(seed);
		data_in = $random(seed);
		be = '1;
		wr = 1'b1;
		rd = 1'b1;
		tick();
		valid = 1'b0;
		wr = 1'b0;
		rd = 1'b0;
		while (pending)
			tick();
		if (op_q[k] == "R") begin
			check_word("data_out", data_out, exp_q[k]);
			last_read = exp_q[k];
		end else begin
			check_word("data_out", data_out, last_read);
		end
	endtask

	initial begin
		rst_n = 1'b0;
		addr = '0;
		data_in = '0;
		wr = 1'b0;
		rd = 1'b0;
		valid = 1'b0;
		be = '0;
		for (int i = 0; i < (1 << WORD_BITS); i++)
			ref_mem[i] = '0;
		load_patterns();
		cycle_limit = CYCLES_PER_LINE * (op_q.size() + 1) + RESET_CYCLES;
		repeat (RESET_CYCLES) begin
			@(negedge clk);
			checks++;
			if (done !== 1'b0) begin
				$display("Fail time=%0t done got=%b exp=0", $time, done);
				errors++;
			end
		end
		rst_n = 1'b1;
		check_word("data_out", data_out, '0);
		for (int k = 0; k < op_q.size(); k++)
			run_op(k);
		// Done stays low through an idle tail.
		repeat (4)
			tick();
		$display("Checks: %0d, operations: %0d, errors: %0d", checks, op_q.size(), errors);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	initial begin
		wait (cycle_limit > 0);
		while (cycles < cycle_limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout after %0d cycles, done never arrived", cycles);
		$display("Simulation failed");
		$finish;
	end

endmodule : mem_sys_tb

`default_nettype wire

// ==== bench/mem_sys_patterns.txt ====
# op addr data be expected, all hex; op W writes, op R reads
# expected is the word after a write, or the value a read returns
R 00000010 00000000 0 00000000
R 000000fc 00000000 0 00000000
W 00000010 deadbeef f deadbeef
R 00000010 00000000 0 deadbeef
W 00000020 11223344 f 11223344
W 00000020 aabbccdd 5 11bb33dd
R 00000020 00000000 0 11bb33dd
W 00000022 cafef00d 8 cabb33dd
R 00000023 00000000 0 cabb33dd
W 00000104 0badf00d f 0badf00d
R 00000005 00000000 0 0badf00d
W 00000006 12345678 3 0bad5678
W 00000040 5a5a5a5a f 5a5a5a5a
R 00003f04 00000000 0 0bad5678
W 00000010 00000000 0 deadbeef
R 00000010 00000000 0 deadbeef
R 00000030 00000000 0 00000000
R 000000fc 00000000 0 00000000

// ==== verilog.f ====
logic/mem_sys_pkg.sv
logic/axil_if.sv
logic/mem_sys_axil.sv
logic/axil_sram.sv
logic/mem_sys_top.sv
bench/mem_sys_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the memory subsystem testbench with Verilator and run it.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module mem_sys_tb -f verilog.f -o mem_sys_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/mem_sys_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulator exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "Simulation completed successfully"; then
	exit 0
fi
exit 1
